//--- hw/gf_pkg.sv
package gf_pkg;

	// Field GF(2^4) and the binary BCH(15,7) code built on it.
	localparam int gf_m = 4;
	localparam int code_n = 15;
	localparam int code_k = 7;

	// Polynomials are stored with bit i as the coefficient of x^i.
	// Field generator x^4 + x + 1.
	localparam logic [gf_m:0] prim_poly = 5'b1_0011;

	// Minimal polynomial of alpha.
	localparam logic [gf_m:0] min_poly_1 = 5'b1_0011;

	// Minimal polynomial of alpha^3, x^4 + x^3 + x^2 + x + 1.
	localparam logic [gf_m:0] min_poly_3 = 5'b1_1111;

	// Product of the two minimal polynomials, x^8 + x^7 + x^6 + x^4 + 1.
	localparam logic [2*gf_m:0] gen_poly = 9'b1_1101_0001;

	typedef logic [gf_m-1:0] gf_elem_t;

	// Primitive element in polynomial basis.
	localparam gf_elem_t gf_alpha = 4'b0010;

	// Polynomial-basis multiply, reduced modulo prim_poly.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t aa;
		acc = '0;
		aa = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i]) begin
				acc = acc ^ aa;
			end
			// Multiply by x and fold x^4 back in.
			if (aa[gf_m-1]) begin
				aa = (aa << 1) ^ prim_poly[gf_m-1:0];
			end else begin
				aa = aa << 1;
			end
		end
		return acc;
	endfunction

endpackage

//--- hw/bch_pkg.sv
package bch_pkg;

	// Codeword bits carried by one stream beat.
	localparam int beat_bits = 3;

	// Beats in a full codeword.
	localparam int frame_beats = gf_pkg::code_n / beat_bits;

	// One input beat. data[beat_bits-1] is the highest-degree coefficient,
	// so the first beat of a frame holds r14 down to r12.
	typedef struct packed {
		logic [beat_bits-1:0] data;
		logic                 last;
	} beat_t;

	// Per-frame result.
	typedef struct packed {
		gf_pkg::gf_elem_t s1;
		gf_pkg::gf_elem_t s3;
		logic             nonzero;
		logic             len_err;
	} syn_t;

endpackage

//--- hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// Accept when empty or when the held item leaves this cycle.
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// Payload has no reset.
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

//--- hw/bch_rem_lfsr.sv
`timescale 1ns/1ps

module bch_rem_lfsr #(
	parameter int           deg  = gf_pkg::gf_m,
	parameter logic [deg:0] poly = gf_pkg::min_poly_1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic                       shift,
	input  logic [bch_pkg::beat_bits-1:0] bits,
	output logic [deg-1:0]             rem
);

	logic [deg-1:0] rem_q;
	logic [deg-1:0] rem_next;

	// The first beat must fit below the divisor degree.
	if (deg < bch_pkg::beat_bits) begin : g_deg_check
		$error("bch_rem_lfsr: deg smaller than beat width");
	end

	// Unrolled division, one input bit per step, highest degree first.
	// Each step computes (rem * x + bit) mod poly.
	always_comb begin
		logic fb;
		rem_next = rem_q;
		for (int i = bch_pkg::beat_bits - 1; i >= 0; i--) begin
			fb = rem_next[deg-1];
			rem_next = {rem_next[deg-2:0], bits[i]};
			if (fb) begin
				rem_next = rem_next ^ poly[deg-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem_q <= '0;
		end else if (start) begin
			// Same as shifting into a cleared state.
			rem_q <= deg'(bits);
		end else if (shift) begin
			rem_q <= rem_next;
		end
	end

	assign rem = rem_q;

endmodule

//--- hw/bch_syn_eval.sv
`timescale 1ns/1ps

module bch_syn_eval #(
	parameter int power = 1
) (
	input  gf_pkg::gf_elem_t rem,
	output gf_pkg::gf_elem_t syn
);

	typedef logic [gf_pkg::gf_m-1:0][gf_pkg::gf_m-1:0] pow_tbl_t;

	// Entry i holds alpha^(i*power).
	function automatic pow_tbl_t build_tbl();
		pow_tbl_t         t;
		gf_pkg::gf_elem_t aj;
		aj = 4'b0001;
		for (int k = 0; k < power; k++) begin
			aj = gf_pkg::gf_mul(aj, gf_pkg::gf_alpha);
		end
		t[0] = 4'b0001;
		for (int i = 1; i < gf_pkg::gf_m; i++) begin
			t[i] = gf_pkg::gf_mul(t[i-1], aj);
		end
		return t;
	endfunction

	localparam pow_tbl_t pow_tbl = build_tbl();

	// b(alpha^j) as a sum of the selected table entries.
	always_comb begin
		syn = '0;
		for (int i = 0; i < gf_pkg::gf_m; i++) begin
			if (rem[i]) begin
				syn = syn ^ pow_tbl[i];
			end
		end
	end

endmodule

//--- hw/bch_syn_core.sv
`timescale 1ns/1ps

module bch_syn_core (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           core_valid,
	output logic           core_ready,
	input  bch_pkg::beat_t core_beat,
	output logic           res_valid,
	input  logic           res_ready,
	output bch_pkg::syn_t  core_syn
);

	// Counts one past frame_beats so long frames stay flagged.
	localparam int cnt_max = bch_pkg::frame_beats + 1;

	logic [$clog2(cnt_max+1)-1:0] beat_cnt;
	logic                         take;
	logic                         start;
	logic                         shift;
	logic                         len_err_q;
	gf_pkg::gf_elem_t             rem1;
	gf_pkg::gf_elem_t             rem3;
	gf_pkg::gf_elem_t             syn1;
	gf_pkg::gf_elem_t             syn3;

	// Input stalls while a result waits.
	assign core_ready = !res_valid;
	assign take       = core_valid && core_ready;
	assign start      = take && (beat_cnt == '0);
	assign shift      = take && (beat_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt  <= '0;
			len_err_q <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (take) begin
				if (core_beat.last) begin
					beat_cnt  <= '0;
					len_err_q <= (beat_cnt != bch_pkg::frame_beats - 1);
					res_valid <= 1'b1;
				end else if (beat_cnt != cnt_max) begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end else if (res_valid && res_ready) begin
				res_valid <= 1'b0;
			end
		end
	end

	// Remainders of r(x) by each minimal polynomial.
	bch_rem_lfsr #(
		.deg  (gf_pkg::gf_m),
		.poly (gf_pkg::min_poly_1)
	) u_rem1 (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.shift (shift),
		.bits  (core_beat.data),
		.rem   (rem1)
	);

	bch_rem_lfsr #(
		.deg  (gf_pkg::gf_m),
		.poly (gf_pkg::min_poly_3)
	) u_rem3 (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.shift (shift),
		.bits  (core_beat.data),
		.rem   (rem3)
	);

	bch_syn_eval #(.power(1)) u_eval1 (
		.rem (rem1),
		.syn (syn1)
	);

	bch_syn_eval #(.power(3)) u_eval3 (
		.rem (rem3),
		.syn (syn3)
	);

	always_comb begin
		core_syn.s1      = syn1;
		core_syn.s3      = syn3;
		core_syn.nonzero = (syn1 != '0) || (syn3 != '0);
		core_syn.len_err = len_err_q;
	end

endmodule

//--- hw/bch_syndrome_top.sv
`timescale 1ns/1ps

module bch_syndrome_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	output logic           in_ready,
	input  bch_pkg::beat_t in_beat,
	output logic           out_valid,
	input  logic           out_ready,
	output bch_pkg::syn_t  out_syn
);

	logic           core_valid;
	logic           core_ready;
	bch_pkg::beat_t core_beat;
	logic           res_valid;
	logic           res_ready;
	bch_pkg::syn_t  core_syn;

	pipe_reg #(.payload_t(bch_pkg::beat_t)) u_in (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_beat),
		.out_valid (core_valid),
		.out_ready (core_ready),
		.out_data  (core_beat)
	);

	bch_syn_core u_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_valid (core_valid),
		.core_ready (core_ready),
		.core_beat  (core_beat),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.core_syn   (core_syn)
	);

	pipe_reg #(.payload_t(bch_pkg::syn_t)) u_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (res_valid),
		.in_ready  (res_ready),
		.in_data   (core_syn),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_syn)
	);

endmodule

//--- tb/bch_syndrome_chk.sv
`timescale 1ns/1ps

module bch_syndrome_chk (
	input logic          clk,
	input logic          rst_n,
	input logic          in_ready,
	input logic          out_valid,
	input logic          out_ready,
	input bch_pkg::syn_t out_syn
);

	// A stalled result keeps its valid and payload.
	a_out_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_syn)
	) else $error("out_valid or out_syn changed while the output was stalled");

	a_out_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	a_out_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
		else $error("out_valid high right after reset");

	// With the output free to move, a blocked input reopens on the next cycle.
	a_in_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		!in_ready && (!out_valid || out_ready) |=> in_ready
	) else $error("in_ready stayed low although the output was not stalled");

endmodule

bind bch_syndrome_top bch_syndrome_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_syn   (out_syn)
);

//--- tb/tb_bch_syndrome.sv
`timescale 1ns/1ps

module tb_bch_syndrome;

	localparam int max_beats   = 8;
	localparam int wait_limit  = 200;
	localparam int drain_limit = 2000;

	typedef logic [bch_pkg::beat_bits*max_beats-1:0] bits_t;

	logic           clk;
	logic           rst_n;
	logic           in_valid;
	logic           in_ready;
	bch_pkg::beat_t in_beat;
	logic           out_valid;
	logic           out_ready;
	bch_pkg::syn_t  out_syn;

	bch_pkg::syn_t  exp_q[$];
	int             errors;
	int             sent_cnt;
	int             recv_cnt;
	int             ready_pct;
	int             max_gap;

	bch_syndrome_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_beat   (in_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_syn   (out_syn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("errors: %0d, frames sent: %0d, results received: %0d",
			errors, sent_cnt, recv_cnt);
		$display("TEST FAILED");
		$finish;
	endtask

	// r(a) by Horner's rule, highest coefficient first.
	function automatic gf_pkg::gf_elem_t horner(input bits_t bits, input int nbits,
			input gf_pkg::gf_elem_t a);
		gf_pkg::gf_elem_t acc;
		acc = '0;
		for (int i = nbits - 1; i >= 0; i--) begin
			acc = gf_pkg::gf_mul(acc, a) ^ {3'b000, bits[i]};
		end
		return acc;
	endfunction

	function automatic bch_pkg::syn_t model(input bits_t bits, input int nbeats);
		bch_pkg::syn_t    s;
		gf_pkg::gf_elem_t a3;
		a3 = gf_pkg::gf_mul(gf_pkg::gf_mul(4'h2, 4'h2), 4'h2);
		s.s1      = horner(bits, bch_pkg::beat_bits * nbeats, 4'h2);
		s.s3      = horner(bits, bch_pkg::beat_bits * nbeats, a3);
		s.nonzero = (s.s1 != '0) || (s.s3 != '0);
		s.len_err = (nbeats != bch_pkg::frame_beats);
		return s;
	endfunction

	// Message times generator, carry-less.
	function automatic logic [gf_pkg::code_n-1:0] encode(input logic [gf_pkg::code_k-1:0] msg);
		logic [gf_pkg::code_n-1:0] cw;
		cw = '0;
		for (int i = 0; i < gf_pkg::code_k; i++) begin
			if (msg[i]) begin
				cw = cw ^ (gf_pkg::code_n'(gf_pkg::gen_poly) << i);
			end
		end
		return cw;
	endfunction

	task automatic check_field(input string name, input logic [3:0] exp, input logic [3:0] got);
		assert (got == exp) else begin
			errors++;
			$display("ERROR %s expected %h got %h (result %0d)", name, exp, got, recv_cnt);
		end
	endtask

	task automatic check_result(input bch_pkg::syn_t got);
		bch_pkg::syn_t exp;
		assert (exp_q.size() > 0) else begin
			errors++;
			$display("ERROR a result came out with no frame outstanding");
		end
		if (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			check_field("out_syn.s1", exp.s1, got.s1);
			check_field("out_syn.s3", exp.s3, got.s3);
			check_field("out_syn.nonzero", {3'b000, exp.nonzero}, {3'b000, got.nonzero});
			check_field("out_syn.len_err", {3'b000, exp.len_err}, {3'b000, got.len_err});
		end
		recv_cnt++;
	endtask

	// Holds one beat until the input register takes it.
	task automatic drive_beat(input logic [bch_pkg::beat_bits-1:0] data, input logic last);
		int   waited;
		logic ok;
		in_valid     = 1'b1;
		in_beat.data = data;
		in_beat.last = last;
		waited = 0;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			ok = in_ready;
			@(posedge clk);
			#1;
			waited++;
			if (!ok && waited > wait_limit) begin
				abort_run("in_ready stayed low for too long, the input is stuck");
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic send_frame(input bits_t bits, input int nbeats);
		bch_pkg::syn_t exp;
		int            gap;
		exp = model(bits, nbeats);
		exp_q.push_back(exp);
		sent_cnt++;
		for (int b = 0; b < nbeats; b++) begin
			drive_beat(bits[bch_pkg::beat_bits*(nbeats-1-b) +: bch_pkg::beat_bits],
				b == nbeats - 1);
		end
		gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_random(input int nbeats);
		bits_t bits;
		bits = bits_t'($urandom);
		send_frame(bits, nbeats);
	endtask

	// Codeword with nflips distinct bit errors.
	task automatic send_codeword(input int nflips);
		logic [gf_pkg::code_n-1:0] cw;
		bch_pkg::syn_t             ref_syn;
		int                        p1;
		int                        p2;
		cw = encode(gf_pkg::code_k'($urandom));
		ref_syn = model(bits_t'(cw), bch_pkg::frame_beats);
		assert (!ref_syn.nonzero) else begin
			errors++;
			$display("ERROR model gave nonzero syndromes for a clean codeword");
		end
		p1 = $urandom_range(gf_pkg::code_n - 1, 0);
		p2 = (p1 + $urandom_range(gf_pkg::code_n - 1, 1)) % gf_pkg::code_n;
		if (nflips >= 1) begin
			cw[p1] = ~cw[p1];
		end
		if (nflips >= 2) begin
			cw[p2] = ~cw[p2];
		end
		ref_syn = model(bits_t'(cw), bch_pkg::frame_beats);
		assert (ref_syn.nonzero == (nflips > 0)) else begin
			errors++;
			$display("ERROR model missed %0d bit errors in a codeword", nflips);
		end
		send_frame(bits_t'(cw), bch_pkg::frame_beats);
	endtask

	// Receiver with random back-pressure.
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (ready_pct >= 100) begin
				out_ready = 1'b1;
			end else begin
				out_ready = ($urandom_range(99, 0) < ready_pct);
			end
			@(negedge clk);
			if (rst_n && out_valid && out_ready) begin
				check_result(out_syn);
			end
		end
	end

	initial begin
		int waited;
		void'($urandom(32'h4a33_e2c1));
		errors    = 0;
		sent_cnt  = 0;
		recv_cnt  = 0;
		ready_pct = 100;
		max_gap   = 0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_beat   = '0;
		out_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		ready_pct = 70;
		max_gap   = 3;
		repeat (12) send_codeword(0);
		repeat (8) send_codeword(1);
		repeat (8) send_codeword(2);
		repeat (12) send_random(bch_pkg::frame_beats);
		for (int len = 1; len <= max_beats; len++) begin
			if (len != bch_pkg::frame_beats) begin
				repeat (3) send_random(len);
			end
		end

		// Heavy stall on the output.
		ready_pct = 25;
		max_gap   = 2;
		repeat (20) send_random($urandom_range(max_beats, 1));

		// Back to back, output always ready.
		ready_pct = 100;
		max_gap   = 0;
		repeat (20) send_random($urandom_range(max_beats, 1));

		waited = 0;
		while (recv_cnt < sent_cnt) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > drain_limit) begin
				abort_run("results stopped arriving before every frame was answered");
			end
		end
		// Room for a duplicate result to show up.
		repeat (20) begin
			@(posedge clk);
			#1;
		end
		assert (recv_cnt == sent_cnt) else begin
			errors++;
			$display("ERROR recv_cnt expected %h got %h", sent_cnt, recv_cnt);
		end

		$display("errors: %0d, frames sent: %0d, results received: %0d",
			errors, sent_cnt, recv_cnt);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
hw/gf_pkg.sv
hw/bch_pkg.sv
hw/pipe_reg.sv
hw/bch_rem_lfsr.sv
hw/bch_syn_eval.sv
hw/bch_syn_core.sv
hw/bch_syndrome_top.sv
tb/bch_syndrome_chk.sv
tb/tb_bch_syndrome.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_bch_syndrome
FILELIST  = build.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
